/* Makefile */
# Verilator build and run of the ooo_core testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module ooo_core_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vooo_core_tb | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

/* all.f */
logic/ooo_pkg.sv
logic/dispatch.sv
logic/rs_entry.sv
logic/issue_alu.sv
logic/rob.sv
logic/ooo_core.sv
tb/ooo_core_assert.sv
tb/ooo_core_tb.sv

/* logic/dispatch.sv */
////////////////////////////////////////
// Unknown opcodes allocate with no destination
////////////////////////////////////////
`timescale 1ns/1ps

module dispatch (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          inst_valid,
    input  ooo_pkg::inst_t                inst,
    input  logic [ooo_pkg::rs_depth-1:0]  entry_busy,
    input  logic                          rob_full,
    input  ooo_pkg::rob_tag_t             rob_tail,
    output ooo_pkg::rob_tag_t             rob_read_tag_a,
    output ooo_pkg::rob_tag_t             rob_read_tag_b,
    input  ooo_pkg::operand_t             rob_read_a,
    input  ooo_pkg::operand_t             rob_read_b,
    input  ooo_pkg::cdb_packet_t          cdb,
    input  ooo_pkg::commit_packet_t       commit,
    output logic                          stall,
    output ooo_pkg::rs_packet_t           rs_write,
    output logic [ooo_pkg::rs_depth-1:0]  entry_select,
    output ooo_pkg::rob_alloc_t           rob_alloc
);

    // Architectural state and rename map
    logic [ooo_pkg::xlen-1:0] regs      [ooo_pkg::num_regs];
    logic                     map_valid [ooo_pkg::num_regs];
    ooo_pkg::rob_tag_t        map_tag   [ooo_pkg::num_regs];
    // Tracks the ROB head, commits retire in order
    ooo_pkg::rob_tag_t        retire_tag;

    logic                     is_reg;
    logic                     is_imm;
    logic                     accept;
    logic                     renames;
    ooo_pkg::alu_op_t         op;
    ooo_pkg::reg_idx_t        rs1;
    ooo_pkg::reg_idx_t        rs2;
    ooo_pkg::reg_idx_t        rd;
    logic [ooo_pkg::xlen-1:0] imm_sext;

    // Operand source priority: regfile, ROB value, bus, else wait on tag
    function automatic ooo_pkg::operand_t resolve(
        input logic                     renamed,
        input ooo_pkg::rob_tag_t        tag,
        input logic [ooo_pkg::xlen-1:0] arch_value,
        input ooo_pkg::operand_t        rob_value,
        input ooo_pkg::cdb_packet_t     bus
    );
        ooo_pkg::operand_t res;
        res.ready = 1'b1;
        res.tag   = tag;
        res.value = arch_value;
        if (renamed) begin
            if (rob_value.ready) begin
                res.value = rob_value.value;
            end else if (bus.valid && bus.tag == tag) begin
                res.value = bus.value;
            end else begin
                res.ready = 1'b0;
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign is_reg   = inst.r_form.opcode == ooo_pkg::opcode_op;
    assign is_imm   = inst.i_form.opcode == ooo_pkg::opcode_op_imm;
    assign rs1      = inst.r_form.rs1;
    assign rs2      = inst.r_form.rs2;
    assign rd       = inst.r_form.rd;
    assign imm_sext = {{(ooo_pkg::xlen-12){inst.i_form.imm[11]}}, inst.i_form.imm};

    always_comb begin
        case (inst.i_form.funct3)
            ooo_pkg::funct3_and: op = ooo_pkg::alu_and;
            ooo_pkg::funct3_or:  op = ooo_pkg::alu_or;
            // funct7 bit 5 selects SUB, register form only
            default: op = (is_reg && inst.r_form.funct7[5]) ? ooo_pkg::alu_sub
                                                             : ooo_pkg::alu_add;
        endcase
    end

    // Stall on no free entry or full ROB
    assign stall   = (&entry_busy) || rob_full;
    assign accept  = inst_valid && !stall;
    assign renames = accept && (is_reg || is_imm) && rd != '0;

    // Lowest free entry wins
    always_comb begin
        entry_select = '0;
        for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
            if (!entry_busy[i]) begin
                entry_select    = '0;
                entry_select[i] = accept;
            end
        end
    end

    ////////////////////////////////////////
    // Operand read and packet build
    ////////////////////////////////////////

    assign rob_read_tag_a = map_tag[rs1];
    assign rob_read_tag_b = map_tag[rs2];

    always_comb begin
        rs_write.valid = accept;
        rs_write.op    = op;
        rs_write.dest  = rob_tail;
        rs_write.a     = resolve(map_valid[rs1], map_tag[rs1], regs[rs1], rob_read_a, cdb);
        if (is_imm) begin
            rs_write.b.ready = 1'b1;
            rs_write.b.tag   = '0;
            rs_write.b.value = imm_sext;
        end else begin
            rs_write.b = resolve(map_valid[rs2], map_tag[rs2], regs[rs2], rob_read_b, cdb);
        end
    end

    assign rob_alloc.valid    = accept;
    assign rob_alloc.dest     = rd;
    assign rob_alloc.has_dest = is_reg || is_imm;

    ////////////////////////////////////////
    // Register file and rename map
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            retire_tag <= '0;
            for (int r = 0; r < ooo_pkg::num_regs; r++) begin
                regs[r]      <= '0;
                map_valid[r] <= 1'b0;
                map_tag[r]   <= '0;
            end
        end else begin
            if (commit.valid) begin
                retire_tag <= retire_tag + 1'b1;
                // Clear only if no newer producer took the register
                if (map_valid[commit.index] && map_tag[commit.index] == retire_tag) begin
                    map_valid[commit.index] <= 1'b0;
                end
            end
            if (commit.valid && commit.wr_en) begin
                regs[commit.index] <= commit.value;
            end
            // New mapping overrides a same-cycle clear
            if (renames) begin
                map_valid[rd] <= 1'b1;
                map_tag[rd]   <= rob_tail;
            end
        end
    end

endmodule

/* logic/issue_alu.sv */
////////////////////////////////////////
// Single-cycle ALU, fixed priority select
////////////////////////////////////////
`timescale 1ns/1ps

module issue_alu (
    input  logic                                      clock,
    input  logic                                      reset,
    input  ooo_pkg::rs_packet_t [ooo_pkg::rs_depth-1:0] entries,
    input  logic                [ooo_pkg::rs_depth-1:0] ready,
    output logic                [ooo_pkg::rs_depth-1:0] issue_grant,
    output ooo_pkg::cdb_packet_t                      cdb
);

    ooo_pkg::rs_packet_t      chosen;
    logic [ooo_pkg::xlen-1:0] result;

    // Lowest ready index gets the unit
    always_comb begin
        issue_grant = '0;
        for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
            if (ready[i]) begin
                issue_grant    = '0;
                issue_grant[i] = 1'b1;
            end
        end
    end

    // One-hot mux of the granted packet
    always_comb begin
        chosen = '0;
        for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            if (issue_grant[i]) begin
                chosen = entries[i];
            end
        end
    end

    ////////////////////////////////////////
    // Execute and broadcast
    ////////////////////////////////////////

    always_comb begin
        case (chosen.op)
            ooo_pkg::alu_add: result = chosen.a.value + chosen.b.value;
            ooo_pkg::alu_sub: result = chosen.a.value - chosen.b.value;
            ooo_pkg::alu_and: result = chosen.a.value & chosen.b.value;
            default:          result = chosen.a.value | chosen.b.value;
        endcase
    end

    // Bus is valid the cycle after issue
    always_ff @(posedge clock) begin
        cdb.tag   <= chosen.dest;
        cdb.value <= result;
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= |ready;
        end
    end

endmodule

/* logic/ooo_core.sv */
////////////////////////////////////////
// Source must hold inst while stall is high
// One commit per cycle, in acceptance order
////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  ooo_pkg::inst_t          inst,
    output logic                    stall,
    output ooo_pkg::commit_packet_t commit
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    // Reservation station bank
    ooo_pkg::rs_packet_t                           rs_write;
    ooo_pkg::rs_packet_t [ooo_pkg::rs_depth-1:0]   entries;
    logic                [ooo_pkg::rs_depth-1:0]   entry_select;
    logic                [ooo_pkg::rs_depth-1:0]   entry_busy;
    logic                [ooo_pkg::rs_depth-1:0]   entry_ready;
    logic                [ooo_pkg::rs_depth-1:0]   issue_grant;

    // Broadcast bus
    ooo_pkg::cdb_packet_t cdb;

    // Reorder buffer side
    ooo_pkg::rob_alloc_t rob_alloc;
    ooo_pkg::rob_tag_t   rob_tail;
    logic                rob_full;
    ooo_pkg::rob_tag_t   rob_read_tag_a;
    ooo_pkg::rob_tag_t   rob_read_tag_b;
    ooo_pkg::operand_t   rob_read_a;
    ooo_pkg::operand_t   rob_read_b;

    ////////////////////////////////////////
    // Dispatch and rename
    ////////////////////////////////////////

    dispatch u_dispatch (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .entry_busy     (entry_busy),
        .rob_full       (rob_full),
        .rob_tail       (rob_tail),
        .rob_read_tag_a (rob_read_tag_a),
        .rob_read_tag_b (rob_read_tag_b),
        .rob_read_a     (rob_read_a),
        .rob_read_b     (rob_read_b),
        .cdb            (cdb),
        .commit         (commit),
        .stall          (stall),
        .rs_write       (rs_write),
        .entry_select   (entry_select),
        .rob_alloc      (rob_alloc)
    );

    // One entry per slot, all snoop the same bus
    for (genvar i = 0; i < ooo_pkg::rs_depth; i++) begin : g_entry
        rs_entry u_entry (
            .clock       (clock),
            .reset       (reset),
            .write_en    (entry_select[i]),
            .rs_write    (rs_write),
            .issue_grant (issue_grant[i]),
            .cdb         (cdb),
            .entry       (entries[i]),
            .busy        (entry_busy[i]),
            .ready       (entry_ready[i])
        );
    end

    ////////////////////////////////////////
    // Execute and retire
    ////////////////////////////////////////

    issue_alu u_issue_alu (
        .clock       (clock),
        .reset       (reset),
        .entries     (entries),
        .ready       (entry_ready),
        .issue_grant (issue_grant),
        .cdb         (cdb)
    );

    rob u_rob (
        .clock      (clock),
        .reset      (reset),
        .rob_alloc  (rob_alloc),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full),
        .read_tag_a (rob_read_tag_a),
        .read_tag_b (rob_read_tag_b),
        .read_a     (rob_read_a),
        .read_b     (rob_read_b),
        .cdb        (cdb),
        .commit     (commit)
    );

endmodule

/* logic/ooo_pkg.sv */
////////////////////////////////////////
// Integer ALU ops only, RV32I encodings
// No loads, stores or branches are decoded
////////////////////////////////////////
package ooo_pkg;

    // Core sizes
    localparam int xlen      = 32;
    localparam int num_regs  = 32;
    localparam int rs_depth  = 4;
    localparam int rob_depth = 8;

    // Opcode and funct3 values of the kept instructions
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [2:0] funct3_and    = 3'b111;
    localparam logic [2:0] funct3_or     = 3'b110;

    typedef logic [4:0] reg_idx_t;
    // ROB slot index doubles as rename tag
    typedef logic [2:0] rob_tag_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_form_t;

    // Same 32 bits, decoded per opcode
    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_t;

    ////////////////////////////////////////
    // Packets between blocks
    ////////////////////////////////////////

    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        operand_t a;
        operand_t b;
        rob_tag_t dest;
    } rs_packet_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        logic     has_dest;
    } rob_alloc_t;

    typedef struct packed {
        logic            valid;
        logic            wr_en;
        reg_idx_t        index;
        logic [xlen-1:0] value;
    } commit_packet_t;

endpackage

/* logic/rob.sv */
////////////////////////////////////////
// Retire never blocks, alloc needs not-full
////////////////////////////////////////
`timescale 1ns/1ps

module rob (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::rob_alloc_t     rob_alloc,
    output ooo_pkg::rob_tag_t       rob_tail,
    output logic                    rob_full,
    input  ooo_pkg::rob_tag_t       read_tag_a,
    input  ooo_pkg::rob_tag_t       read_tag_b,
    output ooo_pkg::operand_t       read_a,
    output ooo_pkg::operand_t       read_b,
    input  ooo_pkg::cdb_packet_t    cdb,
    output ooo_pkg::commit_packet_t commit
);

    // Per-slot storage
    ooo_pkg::reg_idx_t        dest_q     [ooo_pkg::rob_depth];
    logic                     has_dest_q [ooo_pkg::rob_depth];
    logic                     complete_q [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0] value_q    [ooo_pkg::rob_depth];

    // Pointers wrap with the tag width
    ooo_pkg::rob_tag_t                   head;
    ooo_pkg::rob_tag_t                   tail;
    logic [$clog2(ooo_pkg::rob_depth):0] count;

    assign rob_tail = tail;
    assign rob_full = count == ooo_pkg::rob_depth;

    ////////////////////////////////////////
    // Value read ports for dispatch
    ////////////////////////////////////////

    always_comb begin
        read_a.ready = complete_q[read_tag_a];
        read_a.tag   = read_tag_a;
        read_a.value = value_q[read_tag_a];
        read_b.ready = complete_q[read_tag_b];
        read_b.tag   = read_tag_b;
        read_b.value = value_q[read_tag_b];
    end

    // Head retires as soon as it is complete
    always_comb begin
        commit.valid = count != '0 && complete_q[head];
        commit.wr_en = commit.valid && has_dest_q[head] && dest_q[head] != '0;
        commit.index = dest_q[head];
        commit.value = value_q[head];
    end

    ////////////////////////////////////////
    // Pointer and status update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
                complete_q[i] <= 1'b0;
            end
        end else begin
            if (rob_alloc.valid) begin
                tail             <= tail + 1'b1;
                complete_q[tail] <= 1'b0;
            end
            // Bus tag is always an in-flight slot
            if (cdb.valid) begin
                complete_q[cdb.tag] <= 1'b1;
            end
            if (commit.valid) begin
                head <= head + 1'b1;
            end
            case ({rob_alloc.valid, commit.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload fields
    always_ff @(posedge clock) begin
        if (rob_alloc.valid) begin
            dest_q[tail]     <= rob_alloc.dest;
            has_dest_q[tail] <= rob_alloc.has_dest;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

endmodule

/* logic/rs_entry.sv */
////////////////////////////////////////
// Write only when free, grant only when ready
////////////////////////////////////////
`timescale 1ns/1ps

module rs_entry (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 write_en,
    input  ooo_pkg::rs_packet_t  rs_write,
    input  logic                 issue_grant,
    input  ooo_pkg::cdb_packet_t cdb,
    output ooo_pkg::rs_packet_t  entry,
    output logic                 busy,
    output logic                 ready
);

    ooo_pkg::rs_packet_t held;
    logic                wake_a;
    logic                wake_b;

    // Tag match on the bus for a waiting operand
    assign wake_a = cdb.valid && !held.a.ready && cdb.tag == held.a.tag;
    assign wake_b = cdb.valid && !held.b.ready && cdb.tag == held.b.tag;

    always_ff @(posedge clock) begin
        if (reset) begin
            held.valid <= 1'b0;
        end else if (write_en) begin
            // Dispatch already forwarded any same-cycle broadcast
            held <= rs_write;
        end else begin
            if (issue_grant) begin
                held.valid <= 1'b0;
            end
            if (wake_a) begin
                held.a.ready <= 1'b1;
                held.a.value <= cdb.value;
            end
            if (wake_b) begin
                held.b.ready <= 1'b1;
                held.b.value <= cdb.value;
            end
        end
    end

    ////////////////////////////////////////
    // Status toward issue and dispatch
    ////////////////////////////////////////

    assign entry = held;
    assign busy  = held.valid;
    assign ready = held.valid && held.a.ready && held.b.ready;

endmodule

/* tb/ooo_core_assert.sv */
////////////////////////////////////////
// Sampled on the rising edge, top ports only
////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core_assert (
    input logic                    clock,
    input logic                    reset,
    input logic                    stall,
    input ooo_pkg::commit_packet_t commit
);

    // A register write never targets x0
    a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
        (commit.valid && commit.wr_en) |-> commit.index != '0)
        else $error("commit writes x0");

    // Core comes out of reset idle
    a_quiet_after_reset: assert property (@(posedge clock)
        reset |=> (!stall && !commit.valid))
        else $error("stall or commit high after reset");

    // Commit strobe always resolved
    a_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(commit.valid))
        else $error("commit.valid unknown");

endmodule

bind ooo_core ooo_core_assert u_assert (
    .clock  (clock),
    .reset  (reset),
    .stall  (stall),
    .commit (commit)
);

/* tb/ooo_core_tb.sv */
////////////////////////////////////////
// Directed tests against an in-order model
// Random fields from a 16-bit Galois LFSR
////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core_tb;

    logic                    clock;
    logic                    reset;
    logic                    inst_valid;
    ooo_pkg::inst_t          inst;
    logic                    stall;
    ooo_pkg::commit_packet_t commit;

    // Model state and scoreboard
    logic [31:0]             model_regs [32];
    ooo_pkg::commit_packet_t expected_q [$];
    ooo_pkg::commit_packet_t exp_commit;
    logic [15:0]             lfsr_state;
    int                      errors;
    int                      checks;
    int                      stall_cycles;

    ooo_core UUT (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .commit     (commit)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Kinds 0..6 are add, sub, and, or, addi, andi, ori
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        logic [2:0] f3;
        case (kind)
            2, 5:    f3 = 3'b111;
            3, 6:    f3 = 3'b110;
            default: f3 = 3'b000;
        endcase
        if (kind < 4) begin
            return {1'b0, kind == 1, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // In-order execution of one accepted word
    task automatic model_exec(input logic [31:0] w);
        logic [31:0]             a;
        logic [31:0]             b;
        ooo_pkg::commit_packet_t c;
        a = model_regs[w[19:15]];
        b = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        c.valid = 1'b1;
        c.index = w[11:7];
        c.wr_en = w[11:7] != 5'd0;
        case (w[14:12])
            3'b111:  c.value = a & b;
            3'b110:  c.value = a | b;
            default: c.value = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
        endcase
        if (c.wr_en) begin
            model_regs[c.index] = c.value;
        end
        expected_q.push_back(c);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // Word stays on the port until a negedge sees stall low
    task automatic push_inst(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] word;
        word = encode(kind, rd, rs1, rs2, imm);
        @(posedge clock);
        inst_valid <= 1'b1;
        inst       <= word;
        @(negedge clock);
        while (stall) begin
            stall_cycles++;
            @(negedge clock);
        end
        model_exec(word);
    endtask

    // Waits until every accepted word has committed
    task automatic drain();
        @(posedge clock);
        inst_valid <= 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic report(input string name, input int base);
        $display("test %s finished with %0d errors", name, errors - base);
    endtask

    // Pops one expected commit per commit cycle
    always @(negedge clock) begin
        if (!reset && commit.valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("Commit at %0t with no instruction outstanding", $time);
            end else begin
                exp_commit = expected_q.pop_front();
                check_value("commit.wr_en", commit.wr_en, exp_commit.wr_en);
                check_value("commit.index", commit.index, exp_commit.index);
                check_value("commit.value", commit.value, exp_commit.value);
            end
        end
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic immediate_ops();
        int base;
        base = errors;
        push_inst(4, 5'd1, 5'd0, 5'd0, 12'hFFB);
        push_inst(4, 5'd2, 5'd0, 5'd0, 12'h123);
        drain();
        push_inst(5, 5'd3, 5'd1, 5'd0, 12'hFFC);
        push_inst(6, 5'd4, 5'd2, 5'd0, 12'hF00);
        push_inst(4, 5'd5, 5'd2, 5'd0, 12'h800);
        drain();
        report("immediates", base);
    endtask

    task automatic dependent_chain();
        int base;
        base = errors;
        push_inst(4, 5'd1, 5'd0, 5'd0, 12'd7);
        push_inst(0, 5'd2, 5'd1, 5'd1, 12'd0);
        push_inst(1, 5'd3, 5'd2, 5'd1, 12'd0);
        // x1 read in the cycle its producer commits
        push_inst(2, 5'd4, 5'd3, 5'd1, 12'd0);
        push_inst(3, 5'd5, 5'd4, 5'd1, 12'd0);
        push_inst(1, 5'd6, 5'd5, 5'd3, 12'd0);
        drain();
        report("chain", base);
    endtask

    // Serial dependency on x1 keeps entries waiting
    task automatic backpressure_burst();
        int base;
        base = errors;
        stall_cycles = 0;
        push_inst(4, 5'd1, 5'd0, 5'd0, 12'd3);
        push_inst(4, 5'd2, 5'd1, 5'd0, 12'd5);
        for (int i = 0; i < 10; i++) begin
            push_inst(i % 4, 5'd1, 5'd1, 5'd2, 12'd0);
        end
        if (stall_cycles == 0) begin
            errors++;
            $display("Stall never rose during the back-pressure burst");
        end
        drain();
        report("backpressure", base);
    endtask

    task automatic x0_writes();
        int base;
        base = errors;
        push_inst(4, 5'd0, 5'd1, 5'd0, 12'd55);
        push_inst(0, 5'd0, 5'd1, 5'd2, 12'd0);
        push_inst(0, 5'd9, 5'd0, 5'd0, 12'd0);
        push_inst(6, 5'd10, 5'd0, 5'd0, 12'd3);
        drain();
        report("x0", base);
    endtask

    task automatic random_programs();
        int          base;
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        base = errors;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 40; i++) begin
                draw_bits(3, kind);
                draw_bits(5, rd);
                draw_bits(5, rs1);
                draw_bits(5, rs2);
                draw_bits(12, imm);
                push_inst(kind % 7, rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]);
            end
            drain();
        end
        report("random", base);
    endtask

    ////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        errors       = 0;
        checks       = 0;
        stall_cycles = 0;
        lfsr_state   = 16'd48;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        immediate_ops();
        dependent_chain();
        backpressure_burst();
        x0_writes();
        random_programs();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Limit of 20 cycles for each of the 107 instructions
    initial begin
        repeat (107 * 20) @(posedge clock);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule
